// ==== rtl/uopPkg.sv ====
// Micro-op decode types
`default_nettype none

package uopPkg;

	// Plain vector types
	typedef logic [31:0] instrT;        // One instruction word
	typedef logic [4:0]  regAddrT;      // Register file address, top bit selects hidden regs
	typedef logic [2:0]  rzSelT;        // Rz substitution, one bit per address port

	// Hidden temporary register
	localparam regAddrT rzIndex = 5'd16;    // Rz sits just above R15

	// Data-processing opcode for the shift MOV
	localparam logic [3:0] movOpcode = 4'b1101;

	// Bit positions inside rzSelT
	localparam int rzBitWa3 = 2;        // Write port gets Rz
	localparam int rzBitRa2 = 1;        // Second read port gets Rz
	localparam int rzBitRa1 = 0;        // First read port gets Rz

	// Sequencer states
	typedef enum logic {
		seqReady,                       // Idle or pass-through
		seqRsr                          // Second half of an RSR expansion
	} seqStateT;

	// Sequencer to address stage
	typedef struct packed {
		instrT instr;                   // Micro-op encoding
		rzSelT rzSel;                   // Which ports use Rz
		logic  noFlagUpdate;            // Suppress CPSR write
		logic  lastUop;                 // Final micro-op of the instruction
	} seqOutT;

	// Micro-op leaving the decode stage
	typedef struct packed {
		instrT   instr;                 // Micro-op encoding
		regAddrT ra1;                   // Rn
		regAddrT ra2;                   // Rm
		regAddrT ra3;                   // Rs, shift amount
		regAddrT wa3;                   // Rd
		logic    noFlagUpdate;          // Suppress CPSR write
		logic    lastUop;               // Final micro-op of the instruction
	} uopT;

endpackage

`default_nettype wire

// ==== rtl/instrSkidBuffer.sv ====
// Instruction skid buffer
`timescale 1ns/10ps
`default_nettype none

module instrSkidBuffer (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          inValid,
	output logic               inReady,
	input  wire uopPkg::instrT inInstr,
	output logic               bufValid,
	input  wire logic          bufReady,
	output uopPkg::instrT      bufInstr
);

	logic          mainValid;      // Head entry occupied
	logic          skidValid;      // Overflow entry occupied
	uopPkg::instrT mainInstr;      // Head payload
	uopPkg::instrT skidInstr;      // Overflow payload
	logic          inFire;         // Input handshake
	logic          mainFree;       // Head empties or leaves this cycle
	logic          skidValidNext;

	assign inFire   = inValid & inReady;
	assign mainFree = ~mainValid | bufReady;    // Head gone or never there
	assign bufValid = mainValid;
	assign bufInstr = mainInstr;

	// Skid fills only when head is stuck
	always_comb begin
		if (mainFree) begin
			skidValidNext = 1'b0;               // Skid drains into head
		end else begin
			skidValidNext = skidValid | inFire;
		end
	end

	// Control state
	always_ff @(posedge clk) begin
		if (reset) begin
			mainValid <= 1'b0;
			skidValid <= 1'b0;
			inReady   <= 1'b0;                  // Low through reset
		end else begin
			if (mainFree) begin
				mainValid <= skidValid | inFire;
			end
			skidValid <= skidValidNext;
			inReady   <= ~skidValidNext;        // Registered, no path from bufReady
		end
	end

	// Payload, order kept by draining skid first
	always_ff @(posedge clk) begin
		if (mainFree) begin
			if (skidValid) begin
				mainInstr <= skidInstr;
			end else if (inFire) begin
				mainInstr <= inInstr;
			end
		end else if (inFire) begin
			skidInstr <= inInstr;               // Head stalled, park here
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uopSequencer.sv ====
// Micro-op sequencer FSM
`timescale 1ns/10ps
`default_nettype none

module uopSequencer (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          bufValid,
	input  wire uopPkg::instrT bufInstr,
	output logic               seqReady,
	output logic               seqValid,
	output uopPkg::seqOutT     seqOut,
	input  wire logic          decReady
);

	uopPkg::seqStateT state;
	uopPkg::seqStateT nextState;
	logic             isRsr;       // Register-shifted register operand
	logic             xfer;        // Micro-op accepted downstream

	// DP class, bit 7 clear, bit 4 set
	assign isRsr = (bufInstr[27:25] == 3'b000) && !bufInstr[7] && bufInstr[4];

	assign seqValid = bufValid;                 // Every buffered word yields a micro-op
	assign xfer     = seqValid & decReady;

	// State only moves on a downstream transfer
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::seqReady;
		end else if (xfer) begin
			state <= nextState;
		end
	end

	// Mealy outputs
	always_comb begin
		nextState           = state;
		seqReady            = 1'b0;             // Hold the instruction by default
		seqOut.instr        = bufInstr;
		seqOut.rzSel        = '0;
		seqOut.noFlagUpdate = ~bufInstr[20];    // Follow S bit
		seqOut.lastUop      = 1'b1;

		case (state)
			uopPkg::seqReady: begin
				if (isRsr) begin
					// MOV Rz, Rm shifted by Rs, flags untouched
					seqOut.instr = {bufInstr[31:25],  // Cond and class
							uopPkg::movOpcode,        // Opcode field
							9'b0,                     // S, Rn and Rd cleared
							bufInstr[11:0]};          // Rs, shift type, Rm
					seqOut.rzSel[uopPkg::rzBitWa3] = 1'b1;  // Write lands in Rz
					seqOut.noFlagUpdate = 1'b1;
					seqOut.lastUop      = 1'b0;
					nextState           = uopPkg::seqRsr;
					// Instruction stays in buffer for second half
				end else begin
					seqReady = decReady;        // Single micro-op, consume now
				end
			end
			uopPkg::seqRsr: begin
				// Original op with Rz as plain operand
				seqOut.instr = {bufInstr[31:12], 12'b0};
				seqOut.rzSel[uopPkg::rzBitRa2] = 1'b1;  // Rm port reads Rz
				seqReady  = decReady;           // Expansion done, release buffer
				nextState = uopPkg::seqReady;
			end
			default: begin
				nextState = uopPkg::seqReady;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/regAddrDecode.sv ====
// Register address stage
`timescale 1ns/10ps
`default_nettype none

module regAddrDecode (
	input  wire logic           clk,
	input  wire logic           reset,
	input  wire logic           seqValid,
	input  wire uopPkg::seqOutT seqOut,
	output logic                decReady,
	output logic                outValid,
	input  wire logic           outReady,
	output uopPkg::uopT         outUop
);

	uopPkg::uopT nextUop;      // Decoded micro-op before the register
	logic [3:0]  rn;
	logic [3:0]  rd;
	logic [3:0]  rs;
	logic [3:0]  rm;

	// Widens a 4-bit field to an address or swaps in Rz
	function automatic uopPkg::regAddrT toAddr(input logic [3:0] field, input logic useRz);
		uopPkg::regAddrT addr;
		if (useRz) begin
			addr = uopPkg::rzIndex;
		end else begin
			addr = {1'b0, field};               // Architectural registers only
		end
		return addr;
	endfunction

	// Register fields
	assign rn = seqOut.instr[19:16];
	assign rd = seqOut.instr[15:12];
	assign rs = seqOut.instr[11:8];
	assign rm = seqOut.instr[3:0];

	always_comb begin
		nextUop.instr        = seqOut.instr;
		nextUop.ra1          = toAddr(rn, seqOut.rzSel[uopPkg::rzBitRa1]);
		nextUop.ra2          = toAddr(rm, seqOut.rzSel[uopPkg::rzBitRa2]);
		nextUop.ra3          = {1'b0, rs};         // Shift amount never from Rz
		nextUop.wa3          = toAddr(rd, seqOut.rzSel[uopPkg::rzBitWa3]);
		nextUop.noFlagUpdate = seqOut.noFlagUpdate;
		nextUop.lastUop      = seqOut.lastUop;
	end

	// Accept when empty or draining
	assign decReady = ~outValid | outReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (decReady) begin
			outValid <= seqValid;
		end
	end

	// Payload held while stalled
	always_ff @(posedge clk) begin
		if (decReady && seqValid) begin
			outUop <= nextUop;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uopDecodeStage.sv ====
// Micro-op decode stage top
`timescale 1ns/10ps
`default_nettype none

module uopDecodeStage (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          inValid,
	output logic               inReady,
	input  wire uopPkg::instrT inInstr,
	output logic               outValid,
	input  wire logic          outReady,
	output uopPkg::uopT        outUop
);

	// Buffer to sequencer
	logic           bufValid;
	logic           seqReady;
	uopPkg::instrT  bufInstr;

	// Sequencer to address stage
	logic           seqValid;
	logic           decReady;
	uopPkg::seqOutT seqOut;

	// Registers the incoming stream, one cycle
	instrSkidBuffer buffer (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inReady  (inReady),
		.inInstr  (inInstr),
		.bufValid (bufValid),
		.bufReady (seqReady),
		.bufInstr (bufInstr)
	);

	// Splits RSR instructions, zero latency
	uopSequencer sequencer (
		.clk      (clk),
		.reset    (reset),
		.bufValid (bufValid),
		.bufInstr (bufInstr),
		.seqReady (seqReady),
		.seqValid (seqValid),
		.seqOut   (seqOut),
		.decReady (decReady)
	);

	// Address build and output register
	regAddrDecode addrStage (
		.clk      (clk),
		.reset    (reset),
		.seqValid (seqValid),
		.seqOut   (seqOut),
		.decReady (decReady),
		.outValid (outValid),
		.outReady (outReady),
		.outUop   (outUop)
	);

endmodule

`default_nettype wire

// ==== tb/uopRefModel.svh ====
// Micro-op reference model
`ifndef UOP_REF_MODEL_SVH
`define UOP_REF_MODEL_SVH

// DP class with a register-shifted register operand
function automatic logic isRsrInstr(input uopPkg::instrT word);
	return (word[27:25] == 3'b000) && (word[7] == 1'b0) && (word[4] == 1'b1);
endfunction

// One micro-op for plain words, two for RSR
function automatic int expectedUopCount(input uopPkg::instrT word);
	if (isRsrInstr(word)) begin
		return 2;
	end
	return 1;
endfunction

// Addresses straight from the fields, Rz where the micro-op asks for it
function automatic uopPkg::uopT buildUop(input uopPkg::instrT word, input logic writeRz,
		input logic readRz, input logic noFlag, input logic last);
	uopPkg::uopT u;
	u.instr = word;
	u.ra1   = {1'b0, word[19:16]};                      // Rn
	u.ra2   = readRz ? 5'd16 : {1'b0, word[3:0]};      // Rm or Rz
	u.ra3   = {1'b0, word[11:8]};                       // Rs
	u.wa3   = writeRz ? 5'd16 : {1'b0, word[15:12]};   // Rd or Rz
	u.noFlagUpdate = noFlag;
	u.lastUop      = last;
	return u;
endfunction

// MOV Rz with the original shifter operand
function automatic uopPkg::uopT firstRsrUop(input uopPkg::instrT word);
	uopPkg::instrT movWord;
	movWord = {word[31:25], 4'b1101, 9'b0, word[11:0]};   // Opcode MOV, S Rn Rd cleared
	return buildUop(movWord, 1'b1, 1'b0, 1'b1, 1'b0);
endfunction

// Original operation reading Rz unshifted
function automatic uopPkg::uopT secondRsrUop(input uopPkg::instrT word);
	uopPkg::instrT opWord;
	opWord = {word[31:12], 12'b0};                        // Shifter operand dropped
	return buildUop(opWord, 1'b0, 1'b1, ~word[20], 1'b1);
endfunction

// Single micro-op, word unchanged
function automatic uopPkg::uopT passUop(input uopPkg::instrT word);
	return buildUop(word, 1'b0, 1'b0, ~word[20], 1'b1);
endfunction

`endif

// ==== tb/uopDecodeStageTb.sv ====
// Decode stage testbench
`timescale 1ns/10ps
`default_nettype none

module uopDecodeStageTb;

	localparam int clkPeriod   = 20;
	localparam int resetCycles = 8;
	localparam int numInstr    = 16;
	localparam int inWaitLimit = 100;       // Cycles an input may stall
	localparam int drainLimit  = 500;       // Cycles to empty the scoreboard
	localparam logic [31:0] lfsrSeed = 32'd90788;

	logic          clk;
	logic          reset;
	logic          inValid;
	logic          inReady;
	uopPkg::instrT inInstr;
	logic          outValid;
	logic          outReady;
	uopPkg::uopT   outUop;

	uopPkg::instrT stimInstr [numInstr];    // Stimulus words
	int            stimCount [numInstr];    // Expected micro-ops per word
	uopPkg::uopT   expectQ [$];             // Scoreboard with the oldest entry first
	uopPkg::uopT   heldUop;                 // Output seen on the last stall
	logic          stalled;                 // Last cycle was valid without ready
	logic          randomReady;             // Back-pressure on
	logic [31:0]   lfsrState = lfsrSeed;

	`include "uopRefModel.svh"

	uopDecodeStage i_dut (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inReady  (inReady),
		.inInstr  (inInstr),
		.outValid (outValid),
		.outReady (outReady),
		.outUop   (outUop)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s actual=%0h expected=%0h", $time, name,
				actual, expected);
			abortRun();
		end
	endtask

	// Every field of the micro-op
	task automatic compareUop(input uopPkg::uopT actual, input uopPkg::uopT expected);
		checkValue("outUop.instr", actual.instr, expected.instr);
		checkValue("outUop.ra1", actual.ra1, expected.ra1);
		checkValue("outUop.ra2", actual.ra2, expected.ra2);
		checkValue("outUop.ra3", actual.ra3, expected.ra3);
		checkValue("outUop.wa3", actual.wa3, expected.wa3);
		checkValue("outUop.noFlagUpdate", actual.noFlagUpdate, expected.noFlagUpdate);
		checkValue("outUop.lastUop", actual.lastUop, expected.lastUop);
	endtask

	task automatic setEntry(input int idx, input uopPkg::instrT word, input int count);
		stimInstr[idx] = word;
		stimCount[idx] = count;
	endtask

	task automatic loadTable();
		setEntry(0,  32'hE0812003, 1);      // ADD r2, r1, r3
		setEntry(1,  32'hE0812413, 2);      // ADD r2, r1, r3, LSL r4
		setEntry(2,  32'hE3A00001, 1);      // MOV r0, #1
		setEntry(3,  32'hE0565837, 2);      // SUBS r5, r6, r7, LSR r8
		setEntry(4,  32'hE0021143, 1);      // AND with immediate shift
		setEntry(5,  32'hE1944A79, 2);      // ORRS r4, r4, r9, ROR r10
		setEntry(6,  32'h10233313, 2);      // EORNE right after another RSR
		setEntry(7,  32'hE0000291, 1);      // MUL with bit 7 set
		setEntry(8,  32'hE1510312, 2);      // CMP r1, r2, LSL r3
		setEntry(9,  32'hE5910000, 1);      // LDR from another class
		setEntry(10, 32'hEA000010, 1);      // B
		setEntry(11, 32'hE0687A59, 2);      // RSB r7, r8, r9, ASR r10
		setEntry(12, 32'hE0ACBE1D, 2);      // ADC r11, r12, r13, LSL r14
		setEntry(13, 32'hE1B00001, 1);      // MOVS r0, r1
		setEntry(14, 32'hE1C320A4, 1);      // BIC with immediate shift
		setEntry(15, 32'hE1350756, 2);      // TEQ r5, r6, ASR r7
	endtask

	// Expected micro-ops at the moment the word is accepted
	task automatic pushExpected(input uopPkg::instrT word, input int count);
		checkValue("expectedUopCount", expectedUopCount(word), count);
		if (isRsrInstr(word)) begin
			expectQ.push_back(firstRsrUop(word));
			expectQ.push_back(secondRsrUop(word));
		end else begin
			expectQ.push_back(passUop(word));
		end
	endtask

	// Starts on a falling edge and returns on the one after the transfer
	task automatic sendInstr(input uopPkg::instrT word, input int count);
		int waitCycles;
		waitCycles = 0;
		inValid = 1'b1;
		inInstr = word;
		while (!inReady) begin              // Registered inReady is stable here
			@(negedge clk);
			waitCycles++;
			if (waitCycles > inWaitLimit) begin
				$display("Timeout, input stream never became ready");
				abortRun();
			end
		end
		pushExpected(word, count);
		@(negedge clk);
	endtask

	task automatic runTable();
		for (int i = 0; i < numInstr; i++) begin
			sendInstr(stimInstr[i], stimCount[i]);  // inValid stays high between words
		end
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		int waitCycles;
		waitCycles = 0;
		while (expectQ.size() != 0) begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > drainLimit) begin
				$display("Timeout, %0d expected micro-ops never came out", expectQ.size());
				abortRun();
			end
		end
	endtask

	// Drives outReady and scores each output transfer
	initial begin : outputMonitor
		uopPkg::uopT expUop;
		stalled = 1'b0;
		forever begin
			@(negedge clk);
			if (stalled) begin                  // Held output must not move
				checkValue("outValid", outValid, 1'b1);
				checkValue("outUop", outUop, heldUop);
			end
			if (randomReady) begin
				lfsrState = lfsrStep(lfsrState);
				outReady  = lfsrState[0];
			end else begin
				outReady = 1'b1;
			end
			if (outValid && outReady) begin     // Transfer on the coming rising edge
				if (expectQ.size() == 0) begin
					$display("A micro-op came out with none expected at time %0t", $time);
					abortRun();
				end else begin
					expUop = expectQ.pop_front();
					compareUop(outUop, expUop);
				end
			end
			stalled = outValid & ~outReady;
			heldUop = outUop;
		end
	end

	initial begin : mainSequence
		reset       = 1'b1;
		inValid     = 1'b0;
		inInstr     = '0;
		outReady    = 1'b0;
		randomReady = 1'b0;
		loadTable();

		repeat (resetCycles) begin
			@(negedge clk);
			checkValue("outValid", outValid, 1'b0);
			checkValue("inReady", inReady, 1'b0);
		end
		reset = 1'b0;
		@(negedge clk);
		checkValue("outValid", outValid, 1'b0);
		checkValue("inReady", inReady, 1'b1);  // Ready one cycle after reset

		// Full-rate stream with the output always ready
		runTable();
		waitDrain();

		// Same stream under random back-pressure
		randomReady = 1'b1;
		runTable();
		waitDrain();
		randomReady = 1'b0;

		repeat (4) @(negedge clk);          // Catch any stray extra output
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uopDecodeStage.f ====
+incdir+tb
rtl/uopPkg.sv
rtl/instrSkidBuffer.sv
rtl/uopSequencer.sv
rtl/regAddrDecode.sv
rtl/uopDecodeStage.sv
tb/uopDecodeStageTb.sv

// ==== Bender.yml ====
package:
  name: uop_decode_stage

sources:
  - files:
      - rtl/uopPkg.sv
      - rtl/instrSkidBuffer.sv
      - rtl/uopSequencer.sv
      - rtl/regAddrDecode.sv
      - rtl/uopDecodeStage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/uopDecodeStageTb.sv
